/* theiaPkg.sv */
package theiaPkg;

	// --------------------
	// widths
	// --------------------
	localparam int romAddrWidth = 8;
	localparam int dataAddrWidth = 8;
	localparam int laneWidth = 16;
	localparam int instrWidth = 32;

	// one data row, lane x in the top bits
	typedef struct packed {
		logic [laneWidth-1:0] x;
		logic [laneWidth-1:0] y;
		logic [laneWidth-1:0] z;
	} vectorRow;

	// --------------------
	// instruction set
	// --------------------
	typedef enum logic [3:0] {
		opAdd  = 4'd0,
		opSub  = 4'd1,
		opMul  = 4'd2,
		opMove = 4'd3,
		opBeq  = 4'd4,
		opBne  = 4'd5,
		opOut  = 4'd6,
		opRet  = 4'd7
	} opcode;

	// destination doubles as branch target for opBeq and opBne
	typedef struct packed {
		opcode operation;
		logic [7:0] destination;
		logic [7:0] source0;
		logic [7:0] source1;
		logic [3:0] spare;
	} instruction;

endpackage

/* execUnitIf.sv */
`timescale 1ns/1ns

// decoded instruction with both source rows already read
interface decodeIf
	import theiaPkg::*;
	#(parameter int DataAddrWidth = dataAddrWidth)
	();

	logic valid;
	opcode operation;
	logic [DataAddrWidth-1:0] destination;
	vectorRow source0;
	vectorRow source1;

	modport source (output valid, operation, destination, source0, source1);
	modport sink (input valid, operation, destination, source0, source1);

endinterface

// requests to the vector ALU and its answers
interface aluIf
	import theiaPkg::*;
	();

	logic trigger;
	opcode operation;
	vectorRow operandA;
	vectorRow operandB;
	vectorRow result;
	logic ready;
	logic branchTaken;
	logic outputWriteDone;

	modport master (
		output trigger, operation, operandA, operandB,
		input result, ready, branchTaken, outputWriteDone
	);
	modport slave (
		input trigger, operation, operandA, operandB,
		output result, ready, branchTaken, outputWriteDone
	);

endinterface

/* entryPoint.sv */
`timescale 1ns/1ns

module entryPoint
	import theiaPkg::*;
	#(parameter int RomAddrWidth = romAddrWidth)
(
	input logic Clock,
	input logic rst,
	input logic trigger,
	input logic [RomAddrWidth-1:0] initialCodeAddress,
	input logic [instrWidth-1:0] instructionWord,
	output logic busy,
	output logic [RomAddrWidth-1:0] instructionAddress,
	output logic [RomAddrWidth-1:0] entryAddress,
	output logic start
);

	typedef enum logic {
		idle,
		readPointer
	} entryState;

	entryState state;
	logic [RomAddrWidth-1:0] codeAddress;

	// rom address belongs to this block while the lookup runs
	assign busy = (state == readPointer);
	assign instructionAddress = codeAddress;

	always_ff @(posedge Clock) begin
		if (trigger) begin
			codeAddress <= initialCodeAddress;
		end
		if (state == readPointer && !trigger) begin
			entryAddress <= instructionWord[RomAddrWidth-1:0];
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= idle;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				idle: begin
					if (trigger) begin
						state <= readPointer;
					end
				end
				readPointer: begin
					// another trigger simply restarts the lookup
					if (!trigger) begin
						start <= 1'b1;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

/* instructionFetch.sv */
`timescale 1ns/1ns

module instructionFetch
	import theiaPkg::*;
	#(parameter int RomAddrWidth = romAddrWidth)
(
	input logic Clock,
	input logic rst,
	input logic start,
	input logic [RomAddrWidth-1:0] entryAddress,
	input logic [instrWidth-1:0] instructionWord,
	input logic exeDone,
	input logic jumpFlag,
	input logic [RomAddrWidth-1:0] jumpIp,
	input logic finish,
	input logic finishCode,
	output logic [RomAddrWidth-1:0] instructionPointer,
	output instruction currentInstruction,
	output logic instructionAvailable,
	output logic returnCode,
	output logic done
);

	// waitExe stands for the wait state, wait being reserved
	typedef enum logic [1:0] {
		idle,
		fetch,
		waitExe
	} fetchState;

	fetchState state;

	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= idle;
			instructionPointer <= '0;
			instructionAvailable <= 1'b0;
			returnCode <= 1'b0;
			done <= 1'b0;
		end else begin
			instructionAvailable <= 1'b0;
			if (start) begin
				instructionPointer <= entryAddress;
				done <= 1'b0;
				state <= fetch;
			end else begin
				case (state)
					fetch: begin
						instructionAvailable <= 1'b1;
						state <= waitExe;
					end
					waitExe: begin
						if (finish) begin
							done <= 1'b1;
							returnCode <= finishCode;
							state <= idle;
						end else if (exeDone) begin
							if (jumpFlag) begin
								instructionPointer <= jumpIp;
							end else begin
								instructionPointer <= instructionPointer + 1'b1;
							end
							state <= fetch;
						end
					end
					default: state <= idle;
				endcase
			end
		end
	end

	// rom word has settled one cycle after the pointer load
	always_ff @(posedge Clock) begin
		if (state == fetch && !start) begin
			currentInstruction <= instruction'(instructionWord);
		end
	end

endmodule

/* instructionDecode.sv */
`timescale 1ns/1ns

module instructionDecode
	import theiaPkg::*;
	#(parameter int DataAddrWidth = dataAddrWidth)
(
	input logic Clock,
	input logic rst,
	input instruction currentInstruction,
	input logic instructionAvailable,
	input vectorRow dataRead0,
	input vectorRow dataRead1,
	output logic [DataAddrWidth-1:0] dataReadAddress0,
	output logic [DataAddrWidth-1:0] dataReadAddress1,
	decodeIf.source dec
);

	instruction decoded;
	logic readPending;

	// source fields address the data ram directly
	assign dataReadAddress0 = DataAddrWidth'(decoded.source0);
	assign dataReadAddress1 = DataAddrWidth'(decoded.source1);

	// --------------------
	// control
	// --------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			readPending <= 1'b0;
			dec.valid <= 1'b0;
		end else begin
			readPending <= instructionAvailable;
			dec.valid <= readPending;
		end
	end

	// --------------------
	// operand latch
	// --------------------
	always_ff @(posedge Clock) begin
		if (instructionAvailable) begin
			decoded <= currentInstruction;
		end
		// bundle only changes together with valid
		if (readPending) begin
			dec.operation <= decoded.operation;
			dec.destination <= DataAddrWidth'(decoded.destination);
			dec.source0 <= dataRead0;
			dec.source1 <= dataRead1;
		end
	end

endmodule

/* executionFsm.sv */
`timescale 1ns/1ns

module executionFsm
	import theiaPkg::*;
	#(
		parameter int RomAddrWidth = romAddrWidth,
		parameter int DataAddrWidth = dataAddrWidth
	)
(
	input logic Clock,
	input logic rst,
	decodeIf.sink dec,
	aluIf.master alu,
	output logic dataWriteEnable,
	output logic [DataAddrWidth-1:0] dataWriteAddress,
	output vectorRow dataBus,
	output logic exeDone,
	output logic jumpFlag,
	output logic [RomAddrWidth-1:0] jumpIp,
	output logic finish,
	output logic finishCode
);

	typedef enum logic [1:0] {
		idle,
		aluWait,
		writeBack
	} exeState;

	exeState state;
	logic writesRam;
	logic aluAnswer;

	// arithmetic and move results go back to the data ram
	always_comb begin
		case (alu.operation)
			opAdd, opSub, opMul, opMove: writesRam = 1'b1;
			default: writesRam = 1'b0;
		endcase
	end

	assign aluAnswer = (state == aluWait) && alu.ready;

	// --------------------
	// sequencing
	// --------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= idle;
			alu.trigger <= 1'b0;
			dataWriteEnable <= 1'b0;
			exeDone <= 1'b0;
			jumpFlag <= 1'b0;
			finish <= 1'b0;
			finishCode <= 1'b0;
		end else begin
			alu.trigger <= 1'b0;
			dataWriteEnable <= 1'b0;
			exeDone <= 1'b0;
			finish <= 1'b0;
			case (state)
				idle: begin
					if (dec.valid) begin
						alu.trigger <= 1'b1;
						state <= aluWait;
					end
				end
				aluWait: begin
					if (alu.ready) begin
						jumpFlag <= 1'b0;
						if (writesRam) begin
							dataWriteEnable <= 1'b1;
							state <= writeBack;
						end else if (alu.operation == opRet) begin
							finish <= 1'b1;
							finishCode <= alu.operandA.x[0];
							state <= idle;
						end else begin
							// opOut completes with the output memory write
							if (alu.operation == opOut) begin
								exeDone <= alu.outputWriteDone;
							end else begin
								exeDone <= 1'b1;
							end
							jumpFlag <= alu.branchTaken;
							state <= idle;
						end
					end
				end
				writeBack: begin
					exeDone <= 1'b1;
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// --------------------
	// operands and results
	// --------------------
	always_ff @(posedge Clock) begin
		if (state == idle && dec.valid) begin
			alu.operation <= dec.operation;
			alu.operandA <= dec.source0;
			alu.operandB <= dec.source1;
		end
		if (aluAnswer) begin
			dataWriteAddress <= dec.destination;
			dataBus <= alu.result;
			jumpIp <= RomAddrWidth'(dec.destination);
		end
	end

endmodule

/* vectorAlu.sv */
`timescale 1ns/1ns

module vectorAlu
	import theiaPkg::*;
(
	input logic Clock,
	input logic rst,
	aluIf.slave alu,
	output logic outputWriteEnable,
	output logic [laneWidth-1:0] outputWriteAddress,
	output vectorRow outputWriteData
);

	vectorRow laneResult;
	logic xEqual;
	logic isOut;

	// one lane, results wrap at the lane width
	function automatic logic [laneWidth-1:0] laneOp(
		input opcode op,
		input logic [laneWidth-1:0] a,
		input logic [laneWidth-1:0] b
	);
		case (op)
			opAdd: laneOp = a + b;
			opSub: laneOp = a - b;
			opMul: laneOp = a * b;
			default: laneOp = a;
		endcase
	endfunction

	always_comb begin
		laneResult.x = laneOp(alu.operation, alu.operandA.x, alu.operandB.x);
		laneResult.y = laneOp(alu.operation, alu.operandA.y, alu.operandB.y);
		laneResult.z = laneOp(alu.operation, alu.operandA.z, alu.operandB.z);
	end

	// branches only look at lane x
	assign xEqual = (alu.operandA.x == alu.operandB.x);
	assign isOut = (alu.operation == opOut);

	// --------------------
	// strobes
	// --------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			alu.ready <= 1'b0;
			alu.branchTaken <= 1'b0;
			alu.outputWriteDone <= 1'b0;
			outputWriteEnable <= 1'b0;
		end else begin
			alu.ready <= alu.trigger;
			alu.branchTaken <= alu.trigger && (
				(alu.operation == opBeq && xEqual) ||
				(alu.operation == opBne && !xEqual));
			alu.outputWriteDone <= alu.trigger && isOut;
			outputWriteEnable <= alu.trigger && isOut;
		end
	end

	// --------------------
	// result and output row
	// --------------------
	always_ff @(posedge Clock) begin
		if (alu.trigger) begin
			alu.result <= laneResult;
			outputWriteAddress <= alu.operandB.x;
			outputWriteData <= alu.operandA;
		end
	end

endmodule

/* executionUnit.sv */
`timescale 1ns/1ns

module executionUnit
	import theiaPkg::*;
	#(
		parameter int RomAddrWidth = romAddrWidth,
		parameter int DataAddrWidth = dataAddrWidth
	)
(
	input logic Clock,
	input logic rst,
	input logic trigger,
	input logic [RomAddrWidth-1:0] initialCodeAddress,
	input logic [instrWidth-1:0] instructionWord,
	input vectorRow dataRead0,
	input vectorRow dataRead1,
	output logic [RomAddrWidth-1:0] instructionPointer,
	output logic [DataAddrWidth-1:0] dataReadAddress0,
	output logic [DataAddrWidth-1:0] dataReadAddress1,
	output logic dataWriteEnable,
	output logic [DataAddrWidth-1:0] dataWriteAddress,
	output vectorRow dataBus,
	output logic outputWriteEnable,
	output logic [laneWidth-1:0] outputWriteAddress,
	output vectorRow outputWriteData,
	output logic returnCode,
	output logic done
);

	logic entryBusy;
	logic [RomAddrWidth-1:0] entryIp;
	logic [RomAddrWidth-1:0] entryAddress;
	logic fetchStart;
	logic [RomAddrWidth-1:0] fetchIp;
	instruction currentInstruction;
	logic instructionAvailable;
	logic exeDone;
	logic jumpFlag;
	logic [RomAddrWidth-1:0] jumpIp;
	logic finish;
	logic finishCode;
	logic exeReset;

	decodeIf #(.DataAddrWidth(DataAddrWidth)) decodeBus ();
	aluIf aluBus ();

	// entry lookup owns the rom port while busy
	assign instructionPointer = entryBusy ? entryIp : fetchIp;

	// a new trigger abandons whatever instruction is in flight
	assign exeReset = rst | trigger;

	entryPoint #(.RomAddrWidth(RomAddrWidth)) entry (
		.Clock(Clock),
		.rst(rst),
		.trigger(trigger),
		.initialCodeAddress(initialCodeAddress),
		.instructionWord(instructionWord),
		.busy(entryBusy),
		.instructionAddress(entryIp),
		.entryAddress(entryAddress),
		.start(fetchStart)
	);

	instructionFetch #(.RomAddrWidth(RomAddrWidth)) fetch (
		.Clock(Clock),
		.rst(rst),
		.start(fetchStart),
		.entryAddress(entryAddress),
		.instructionWord(instructionWord),
		.exeDone(exeDone),
		.jumpFlag(jumpFlag),
		.jumpIp(jumpIp),
		.finish(finish),
		.finishCode(finishCode),
		.instructionPointer(fetchIp),
		.currentInstruction(currentInstruction),
		.instructionAvailable(instructionAvailable),
		.returnCode(returnCode),
		.done(done)
	);

	// --------------------
	// decode and execute
	// --------------------
	instructionDecode #(.DataAddrWidth(DataAddrWidth)) decode (
		.Clock(Clock),
		.rst(rst),
		.currentInstruction(currentInstruction),
		.instructionAvailable(instructionAvailable),
		.dataRead0(dataRead0),
		.dataRead1(dataRead1),
		.dataReadAddress0(dataReadAddress0),
		.dataReadAddress1(dataReadAddress1),
		.dec(decodeBus.source)
	);

	executionFsm #(
		.RomAddrWidth(RomAddrWidth),
		.DataAddrWidth(DataAddrWidth)
	) exe (
		.Clock(Clock),
		.rst(exeReset),
		.dec(decodeBus.sink),
		.alu(aluBus.master),
		.dataWriteEnable(dataWriteEnable),
		.dataWriteAddress(dataWriteAddress),
		.dataBus(dataBus),
		.exeDone(exeDone),
		.jumpFlag(jumpFlag),
		.jumpIp(jumpIp),
		.finish(finish),
		.finishCode(finishCode)
	);

	vectorAlu alu (
		.Clock(Clock),
		.rst(rst),
		.alu(aluBus.slave),
		.outputWriteEnable(outputWriteEnable),
		.outputWriteAddress(outputWriteAddress),
		.outputWriteData(outputWriteData)
	);

endmodule

/* tbExecutionUnit.sv */
`timescale 1ns/1ns

module tbExecutionUnit
	import theiaPkg::*;
();

	logic Clock;
	logic rst;
	logic trigger;
	logic [romAddrWidth-1:0] initialCodeAddress;
	logic [instrWidth-1:0] instructionWord;
	vectorRow dataRead0;
	vectorRow dataRead1;
	logic [romAddrWidth-1:0] instructionPointer;
	logic [dataAddrWidth-1:0] dataReadAddress0;
	logic [dataAddrWidth-1:0] dataReadAddress1;
	logic dataWriteEnable;
	logic [dataAddrWidth-1:0] dataWriteAddress;
	vectorRow dataBus;
	logic outputWriteEnable;
	logic [laneWidth-1:0] outputWriteAddress;
	vectorRow outputWriteData;
	logic returnCode;
	logic done;

	logic [31:0] rom [256];
	vectorRow dataRam [256];
	vectorRow refRam [256];
	logic [55:0] expData [$];
	logic [63:0] expOut [$];
	logic [55:0] expWrite;
	logic [63:0] expOutWrite;
	int expWrites [3];
	int expOutCount [3];
	logic expCode [3];
	int seenWrites;
	int seenOut;
	int totalInstr;
	int cycleCount;
	int cycleLimit;
	int valueErrors;
	int otherErrors;
	logic [31:0] lfsrState = 32'h5fea9df8;

	executionUnit #(.RomAddrWidth(romAddrWidth), .DataAddrWidth(dataAddrWidth)) i_dut (.*);

	// combinational memory models
	assign instructionWord = rom[instructionPointer];
	assign dataRead0 = dataRam[dataReadAddress0];
	assign dataRead1 = dataRam[dataReadAddress1];

	always @(posedge Clock) begin
		if (dataWriteEnable) begin
			dataRam[dataWriteAddress] <= dataBus;
		end
	end

	initial begin
		Clock = 1'b0;
		forever #20 Clock = ~Clock;
	end

	// --------------------
	// helpers
	// --------------------
	function automatic logic [15:0] randomLane();
		logic [15:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < 16; i++) begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			value = {value[14:0], feedback};
		end
		return value;
	endfunction

	function automatic logic [31:0] encode(input opcode op, input logic [7:0] dest,
			input logic [7:0] src0, input logic [7:0] src1);
		instruction ins;
		ins.operation = op;
		ins.destination = dest;
		ins.source0 = src0;
		ins.source1 = src1;
		ins.spare = 4'h0;
		return ins;
	endfunction

	// lane arithmetic done wide, then reduced mod 2^16
	function automatic logic [15:0] refLane(input opcode op, input logic [15:0] a,
			input logic [15:0] b);
		longint wide;
		case (op)
			opAdd: wide = longint'(a) + longint'(b);
			opSub: wide = longint'(a) - longint'(b) + 65536;
			opMul: wide = longint'(a) * longint'(b);
			default: wide = longint'(a);
		endcase
		return 16'(wide % 65536);
	endfunction

	task automatic logMismatch(input string msg);
		valueErrors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	task automatic reportFailure(input string msg);
		otherErrors++;
		$display("%s", msg);
	endtask

	task automatic loadMemories();
		for (int i = 0; i < 256; i++) begin
			// stray fetches land on a return
			rom[i] = encode(opRet, 8'(i), 8'(i), ~8'(i));
			dataRam[i].x = randomLane();
			dataRam[i].y = randomLane();
			dataRam[i].z = randomLane();
		end
		rom[0] = 32'h10;
		rom[1] = {24'h5a5a5a, 8'h40};
		rom[2] = 32'h80;
		// arithmetic program, last add reads earlier results
		rom[8'h10] = encode(opAdd, 8'd20, 8'd1, 8'd2);
		rom[8'h11] = encode(opSub, 8'd21, 8'd3, 8'd4);
		rom[8'h12] = encode(opMul, 8'd22, 8'd5, 8'd6);
		rom[8'h13] = encode(opMove, 8'd23, 8'd7, 8'd0);
		rom[8'h14] = encode(opAdd, 8'd24, 8'd20, 8'd21);
		rom[8'h15] = encode(opRet, 8'd0, 8'd8, 8'd0);
		// branch program, rows 30 and 31 share lane x, row 32 differs
		rom[8'h40] = encode(opBeq, 8'h42, 8'd30, 8'd31);
		rom[8'h41] = encode(opMove, 8'd40, 8'd1, 8'd0);
		rom[8'h42] = encode(opBeq, 8'h44, 8'd30, 8'd32);
		rom[8'h43] = encode(opMove, 8'd41, 8'd2, 8'd0);
		rom[8'h44] = encode(opBne, 8'h46, 8'd30, 8'd32);
		rom[8'h45] = encode(opMove, 8'd42, 8'd3, 8'd0);
		rom[8'h46] = encode(opBne, 8'h48, 8'd30, 8'd31);
		rom[8'h47] = encode(opMove, 8'd43, 8'd4, 8'd0);
		rom[8'h48] = encode(opRet, 8'd0, 8'd9, 8'd0);
		// output program
		rom[8'h80] = encode(opOut, 8'd0, 8'd10, 8'd11);
		rom[8'h81] = encode(opMul, 8'd25, 8'd10, 8'd12);
		rom[8'h82] = encode(opOut, 8'd0, 8'd25, 8'd13);
		rom[8'h83] = encode(opRet, 8'd0, 8'd14, 8'd0);
		dataRam[31].x = dataRam[30].x;
		dataRam[32].x = dataRam[30].x ^ 16'h0001;
		dataRam[8].x[0] = 1'b1;
		dataRam[9].x[0] = 1'b0;
		dataRam[14].x[0] = 1'b1;
	endtask

	// --------------------
	// reference model
	// --------------------
	task automatic runReference(input int prog, input logic [7:0] entry);
		logic [7:0] ip;
		instruction ins;
		vectorRow a;
		vectorRow b;
		vectorRow r;
		int steps;
		logic finished;
		ip = entry;
		steps = 0;
		finished = 1'b0;
		expWrites[prog] = 0;
		expOutCount[prog] = 0;
		while (!finished && steps < 64) begin
			ins = instruction'(rom[ip]);
			a = refRam[ins.source0];
			b = refRam[ins.source1];
			steps++;
			ip = ip + 8'd1;
			case (ins.operation)
				opAdd, opSub, opMul, opMove: begin
					r.x = refLane(ins.operation, a.x, b.x);
					r.y = refLane(ins.operation, a.y, b.y);
					r.z = refLane(ins.operation, a.z, b.z);
					refRam[ins.destination] = r;
					expData.push_back({ins.destination, r});
					expWrites[prog]++;
				end
				opBeq: if (a.x == b.x) ip = ins.destination;
				opBne: if (a.x != b.x) ip = ins.destination;
				opOut: begin
					expOut.push_back({b.x, a});
					expOutCount[prog]++;
				end
				default: begin
					expCode[prog] = a.x[0];
					finished = 1'b1;
				end
			endcase
		end
		totalInstr += steps;
	endtask

	// --------------------
	// write monitors
	// --------------------
	always @(negedge Clock) begin
		if (dataWriteEnable) begin
			seenWrites++;
			if (expData.size() == 0) begin
				reportFailure($sformatf("unexpected data RAM write to row %0d", dataWriteAddress));
			end else begin
				expWrite = expData.pop_front();
				assert ({dataWriteAddress, dataBus} == expWrite) else
					logMismatch($sformatf("data write row %0d %h, expected row %0d %h",
						dataWriteAddress, dataBus, expWrite[55:48], expWrite[47:0]));
			end
		end
		if (outputWriteEnable) begin
			seenOut++;
			if (expOut.size() == 0) begin
				reportFailure($sformatf("unexpected output write to %0d", outputWriteAddress));
			end else begin
				expOutWrite = expOut.pop_front();
				assert ({outputWriteAddress, outputWriteData} == expOutWrite) else
					logMismatch($sformatf("output write %0d %h, expected %0d %h",
						outputWriteAddress, outputWriteData, expOutWrite[63:48], expOutWrite[47:0]));
			end
		end
	end

	always @(posedge Clock) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("timeout after %0d cycles, errors so far %0d", cycleCount,
				valueErrors + otherErrors);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic runProgram(input int prog, input logic [7:0] lookupAddr);
		logic [7:0] entry;
		entry = rom[lookupAddr][7:0];
		seenWrites = 0;
		seenOut = 0;
		@(posedge Clock);
		initialCodeAddress <= lookupAddr;
		trigger <= 1'b1;
		@(posedge Clock);
		trigger <= 1'b0;
		@(negedge Clock);
		assert (instructionPointer == lookupAddr) else
			logMismatch($sformatf("lookup pointer %h, expected %h", instructionPointer, lookupAddr));
		// two cycles of lookup, then the fetch pointer loads
		@(posedge Clock);
		@(posedge Clock);
		@(negedge Clock);
		assert (instructionPointer == entry) else
			logMismatch($sformatf("first pointer %h, expected %h", instructionPointer, entry));
		assert (!done) else
			logMismatch("done still high after a new trigger");
		while (!done) @(negedge Clock);
		assert (returnCode == expCode[prog]) else
			logMismatch($sformatf("program %0d return code %0d", prog, returnCode));
		assert (seenWrites == expWrites[prog]) else
			logMismatch($sformatf("program %0d made %0d data writes, expected %0d",
				prog, seenWrites, expWrites[prog]));
		assert (seenOut == expOutCount[prog]) else
			logMismatch($sformatf("program %0d made %0d output writes, expected %0d",
				prog, seenOut, expOutCount[prog]));
		repeat (5) @(negedge Clock);
		assert (done) else
			logMismatch("done dropped before the next trigger");
	endtask

	initial begin
		rst = 1'b1;
		trigger = 1'b0;
		initialCodeAddress = '0;
		cycleCount = 0;
		totalInstr = 0;
		valueErrors = 0;
		otherErrors = 0;
		loadMemories();
		refRam = dataRam;
		for (int p = 0; p < 3; p++) begin
			runReference(p, rom[p][7:0]);
		end
		cycleLimit = 12 * totalInstr + 200;
		repeat (10) @(posedge Clock);
		rst <= 1'b0;
		repeat (3) begin
			@(negedge Clock);
			assert (!done && !dataWriteEnable && !outputWriteEnable) else
				logMismatch("outputs not low after reset");
		end
		runProgram(0, 8'd0);
		runProgram(1, 8'd1);
		runProgram(2, 8'd2);
		for (int i = 0; i < 256; i++) begin
			assert (dataRam[i] == refRam[i]) else
				logMismatch($sformatf("final row %0d %h, expected %h", i, dataRam[i], refRam[i]));
		end
		if (expData.size() != 0 || expOut.size() != 0) begin
			reportFailure("expected writes were never seen");
		end
		$display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* build.f */
theiaPkg.sv
execUnitIf.sv
entryPoint.sv
instructionFetch.sv
instructionDecode.sv
executionFsm.sv
vectorAlu.sv
executionUnit.sv
tbExecutionUnit.sv

/* runSim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module tbExecutionUnit -o simExecutionUnit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simExecutionUnit > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "STATUS: PASS" "$logFile"; then
	exit 0
fi
echo "pass message not found in $logFile"
exit 1
